// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rs_encode_tile_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation ended without a result"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/rs_encode_tile_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rs_tile_defs.svh"

module rs_encode_tile_tb
    import noc_msg_pkg::*;
();

    localparam int WAIT_LIMIT = 400;
    localparam int NUM_ROWS   = 13;
    localparam int NSYM       = `RS_PARITY_SYMS;

    typedef struct packed {
        logic [3:0]  mtype;
        logic [7:0]  len;
        logic [15:0] tag;
        logic        rnd;
        logic        rand_rdy;
        logic [7:0]  stall;
        logic        drain;
        logic        check_cnt;
    } row_t;

    logic                           clk;
    logic                           rst;
    logic                           in_val;
    logic   [`NOC_DATA_WIDTH-1:0]   in_data;
    logic                           in_rdy;
    logic                           out_val;
    logic   [`NOC_DATA_WIDTH-1:0]   out_data;
    logic                           out_rdy = 1'b0;

    row_t                           stim [NUM_ROWS];
    logic   [`NOC_DATA_WIDTH-1:0]   exp_q [$];
    logic   [`NOC_DATA_WIDTH-1:0]   mask_q [$];
    logic   [`NOC_DATA_WIDTH-1:0]   exp_flit;
    logic   [`NOC_DATA_WIDTH-1:0]   exp_mask;
    logic   [7:0]                   gen_poly [NSYM+1];
    logic   [7:0]                   div_buf [2048];
    integer                         seed = 25350;
    logic   [31:0]                  rdy_draw = '0;
    logic                           rand_rdy = 1'b0;
    int                             cycle_cnt = 0;
    int                             stall_end = 0;
    logic   [31:0]                  sent_pkts = '0;
    logic   [31:0]                  sent_bytes = '0;
    logic                           aborted = 1'b0;
    int                             value_errs = 0;
    int                             timeout_errs = 0;
    int                             proto_errs = 0;
    int                             out_count = 0;

    tb_clock clk_gen (
         .clk   (clk)
    );

    rs_encode_tile dut_i (
         .clk       (clk        )
        ,.rst       (rst        )
        ,.in_val    (in_val     )
        ,.in_data   (in_data    )
        ,.in_rdy    (in_rdy     )
        ,.out_val   (out_val    )
        ,.out_data  (out_data   )
        ,.out_rdy   (out_rdy    )
    );

    function automatic logic [7:0] xtime(input logic [7:0] x);
        return {x[6:0], 1'b0} ^ (x[7] ? 8'h1D : 8'h00);
    endfunction

    // horner style, top bit of b first
    function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        p = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            p = xtime(p);
            if (b[i]) begin
                p = p ^ a;
            end
        end
        return p;
    endfunction

    // product of (x + alpha^r), highest degree first
    function automatic void build_generator();
        logic [7:0] root;
        root = 8'h01;
        gen_poly[0] = 8'h01;
        for (int k = 1; k <= NSYM; k++) begin
            gen_poly[k] = 8'h00;
        end
        for (int r = 0; r < NSYM; r++) begin
            for (int k = r + 1; k >= 1; k--) begin
                gen_poly[k] = gen_poly[k] ^ gf_mult(root, gen_poly[k-1]);
            end
            root = xtime(root);
        end
    endfunction

    // long division of the bytes in div_buf, padded with NSYM zeros
    function automatic logic [`NOC_DATA_WIDTH-1:0] ref_parity(input int nbytes);
        logic [7:0]                 c;
        logic [`NOC_DATA_WIDTH-1:0] par;
        for (int j = 0; j < NSYM; j++) begin
            div_buf[nbytes + j] = 8'h00;
        end
        for (int i = 0; i < nbytes; i++) begin
            c = div_buf[i];
            for (int j = 1; j <= NSYM; j++) begin
                div_buf[i + j] = div_buf[i + j] ^ gf_mult(c, gen_poly[j]);
            end
        end
        par = '0;
        for (int j = 0; j < NSYM; j++) begin
            par[8*(NSYM-1-j) +: 8] = div_buf[nbytes + j];
        end
        return par;
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] pack_header(
        input logic [3:0]  mtype,
        input logic [7:0]  len,
        input logic [15:0] tag
    );
        return {mtype, len, tag, {(`NOC_DATA_WIDTH-28){1'b0}}};
    endfunction

    function automatic row_t stim_row(
        input logic [3:0]  mtype,
        input logic [7:0]  len,
        input logic [15:0] tag,
        input logic        rnd,
        input logic        rrdy,
        input logic [7:0]  stall,
        input logic        drain,
        input logic        check_cnt
    );
        return '{mtype, len, tag, rnd, rrdy, stall, drain, check_cnt};
    endfunction

    function automatic void fill_stimulus();
        // single packets
        stim[0]  = stim_row(PKT_IN,    8'd1,  16'h0101, 1'b1, 1'b0, 8'd0,  1'b1, 1'b0);
        stim[1]  = stim_row(PKT_IN,    8'd3,  16'h0102, 1'b1, 1'b0, 8'd0,  1'b1, 1'b0);
        stim[2]  = stim_row(PKT_IN,    8'd0,  16'h0103, 1'b0, 1'b0, 8'd0,  1'b1, 1'b0);
        // back to back with random output ready
        stim[3]  = stim_row(PKT_IN,    8'd4,  16'h0201, 1'b1, 1'b1, 8'd0,  1'b1, 1'b0);
        stim[4]  = stim_row(PKT_IN,    8'd2,  16'h0202, 1'b1, 1'b1, 8'd0,  1'b0, 1'b0);
        stim[5]  = stim_row(PKT_IN,    8'd7,  16'h0203, 1'b0, 1'b1, 8'd0,  1'b0, 1'b0);
        stim[6]  = stim_row(PKT_IN,    8'd1,  16'h0204, 1'b1, 1'b1, 8'd0,  1'b0, 1'b0);
        stim[7]  = stim_row(PKT_IN,    8'd5,  16'h0205, 1'b1, 1'b1, 8'd0,  1'b0, 1'b0);
        stim[8]  = stim_row(STATS_REQ, 8'd0,  16'h0301, 1'b0, 1'b0, 8'd0,  1'b1, 1'b1);
        // unknown type then a packet
        stim[9]  = stim_row(4'hA,      8'd2,  16'h0401, 1'b1, 1'b0, 8'd0,  1'b1, 1'b0);
        stim[10] = stim_row(PKT_IN,    8'd2,  16'h0402, 1'b1, 1'b0, 8'd0,  1'b0, 1'b0);
        // stats behind a stalled long packet
        stim[11] = stim_row(PKT_IN,    8'd20, 16'h0501, 1'b1, 1'b0, 8'd40, 1'b1, 1'b0);
        stim[12] = stim_row(STATS_REQ, 8'd0,  16'h0502, 1'b0, 1'b0, 8'd0,  1'b0, 1'b0);
    endfunction

    function automatic void expect_flit(
        input logic [`NOC_DATA_WIDTH-1:0] data,
        input logic [`NOC_DATA_WIDTH-1:0] mask
    );
        exp_q.push_back(data);
        mask_q.push_back(mask);
    endfunction

    // a dropped flit must be taken in its first cycle
    task automatic send_flit(input logic [`NOC_DATA_WIDTH-1:0] data, input logic dropped);
        int   cyc;
        logic accepted;
        cyc      = 0;
        accepted = 1'b0;
        in_val   = 1'b1;
        in_data  = data;
        while (!accepted && cyc < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = in_rdy;
            if (dropped && cyc == 0) begin
                assert (in_rdy === 1'b1) else begin
                    value_errs++;
                    $display("Fail in_rdy got %h expected %h", in_rdy, 1'b1);
                end
            end
            cyc++;
        end
        @(negedge clk);
        in_val = 1'b0;
        if (!accepted) begin
            timeout_errs++;
            aborted = 1'b1;
            $display("timeout: input never accepted flit %h", data);
        end
    endtask

    task automatic wait_drained();
        int cyc;
        cyc = 0;
        while (exp_q.size() != 0 && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (exp_q.size() != 0) begin
            timeout_errs++;
            aborted = 1'b1;
            $display("timeout: %0d expected reply flits never came out", exp_q.size());
        end
    endtask

    task automatic send_message(input row_t r);
        logic [`NOC_DATA_WIDTH-1:0] flit;
        logic [`NOC_DATA_WIDTH-1:0] full_mask;
        logic                       dropped;
        full_mask = '1;
        dropped   = (r.mtype != PKT_IN) && (r.mtype != STATS_REQ);
        if (r.mtype == PKT_IN) begin
            expect_flit(pack_header(PKT_OUT, r.len + 8'd1, r.tag), full_mask);
        end else if (r.mtype == STATS_REQ) begin
            expect_flit(pack_header(STATS_RESP, 8'd1, r.tag), full_mask);
            expect_flit({sent_pkts, sent_bytes}, r.check_cnt ? full_mask : '0);
        end
        send_flit(pack_header(r.mtype, r.len, r.tag), dropped);
        for (int k = 0; k < r.len && !aborted; k++) begin
            if (r.rnd) begin
                flit[63:32] = $random(seed);
                flit[31:0]  = $random(seed);
            end else begin
                flit = {r.tag, 16'(k), 32'hC3A5_5A3C};
            end
            if (r.mtype == PKT_IN) begin
                for (int b = 0; b < 8; b++) begin
                    div_buf[8*k + b] = flit[8*(7-b) +: 8];
                end
                expect_flit(flit, full_mask);
            end
            send_flit(flit, dropped);
        end
        if (r.mtype == PKT_IN) begin
            expect_flit(ref_parity(8 * int'(r.len)), full_mask);
            sent_pkts  = sent_pkts + 32'd1;
            sent_bytes = sent_bytes + 32'(8 * int'(r.len));
        end
    endtask

    always @(posedge clk) begin
        rdy_draw = $random(seed);
    end

    // output ready, held low until stall_end then steady or random
    always @(negedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt < stall_end) begin
            out_rdy <= 1'b0;
        end else if (rand_rdy) begin
            out_rdy <= rdy_draw[0];
        end else begin
            out_rdy <= 1'b1;
        end
    end

    // scoreboard at each output handshake
    always @(posedge clk) begin
        if (!rst && out_val && out_rdy) begin
            assert (exp_q.size() != 0) else begin
                proto_errs++;
                $display("output sent flit %h when no reply was expected", out_data);
            end
            if (exp_q.size() != 0) begin
                exp_flit = exp_q.pop_front();
                exp_mask = mask_q.pop_front();
                assert (((out_data ^ exp_flit) & exp_mask) == '0) else begin
                    value_errs++;
                    $display("Fail out_data flit %0d got %h expected %h",
                             out_count, out_data, exp_flit);
                end
            end
            out_count++;
        end
    end

    initial begin
        rst     = 1'b1;
        in_val  = 1'b0;
        in_data = '0;
        build_generator();
        fill_stimulus();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        assert (out_val === 1'b0) else begin
            value_errs++;
            $display("Fail out_val got %h expected %h", out_val, 1'b0);
        end
        @(negedge clk);
        for (int i = 0; i < NUM_ROWS && !aborted; i++) begin
            if (stim[i].drain) begin
                wait_drained();
            end
            if (!aborted) begin
                rand_rdy <= stim[i].rand_rdy;
                if (stim[i].stall != 0) begin
                    stall_end <= cycle_cnt + int'(stim[i].stall);
                end
                send_message(stim[i]);
            end
        end
        rand_rdy <= 1'b0;
        if (!aborted) begin
            wait_drained();
        end
        // idle a little to catch stray output flits
        repeat (10) @(negedge clk);
        $display("error counts: value %0d, timeout %0d, protocol %0d",
                 value_errs, timeout_errs, proto_errs);
        if (value_errs + timeout_errs + proto_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
     parameter int HALF_PERIOD = 20
)(
     output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
     parameter int WIDTH      = 64
    ,parameter int LOG2_DEPTH = 5
)(
     input  wire                clk
    ,input  wire                rst

    ,input  wire                wr_req
    ,input  wire    [WIDTH-1:0] wr_data
    ,output logic               full

    ,input  wire                rd_req
    ,output logic   [WIDTH-1:0] rd_data
    ,output logic               empty
);

    localparam int DEPTH = 1 << LOG2_DEPTH;

    logic [WIDTH-1:0]       mem [DEPTH];
    // extra top bit tells full from empty
    logic [LOG2_DEPTH:0]    wr_ptr;
    logic [LOG2_DEPTH:0]    rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[LOG2_DEPTH] != rd_ptr[LOG2_DEPTH])
                 & (wr_ptr[LOG2_DEPTH-1:0] == rd_ptr[LOG2_DEPTH-1:0]);

    assign rd_data = mem[rd_ptr[LOG2_DEPTH-1:0]];

    always_ff @(posedge clk) begin
        if (wr_req && !full) begin
            mem[wr_ptr[LOG2_DEPTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_req && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_req && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/noc_fbits_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rs_tile_defs.svh"

module noc_fbits_decode
    import noc_msg_pkg::*;
(
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            in_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   in_data
    ,output logic                           in_rdy

    ,output logic                           pkt_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   pkt_data
    ,input  wire                            pkt_rdy

    ,output logic                           stat_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   stat_data
    ,input  wire                            stat_rdy
);

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_PKT,
        TGT_STAT,
        TGT_DROP
    } target_e;

    target_e                    tgt;
    target_e                    hdr_tgt;
    target_e                    cur_tgt;
    logic [`MSG_LEN_WIDTH-1:0]  left;
    logic                       in_hs;

    always_comb begin
        case (hdr_type(in_data))
            PKT_IN:    hdr_tgt = TGT_PKT;
            STATS_REQ: hdr_tgt = TGT_STAT;
            default:   hdr_tgt = TGT_DROP;
        endcase
    end

    // no lock means the flit at the input is a header
    assign cur_tgt = (tgt == TGT_NONE) ? hdr_tgt : tgt;

    assign pkt_val   = in_val & (cur_tgt == TGT_PKT);
    assign stat_val  = in_val & (cur_tgt == TGT_STAT);
    assign pkt_data  = in_data;
    assign stat_data = in_data;

    always_comb begin
        case (cur_tgt)
            TGT_PKT:  in_rdy = pkt_rdy;
            TGT_STAT: in_rdy = stat_rdy;
            default:  in_rdy = 1'b1;
        endcase
    end

    assign in_hs = in_val & in_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            tgt  <= TGT_NONE;
            left <= '0;
        end else if (in_hs) begin
            if (tgt == TGT_NONE) begin
                if (hdr_len(in_data) != '0) begin
                    tgt  <= hdr_tgt;
                    left <= hdr_len(in_data);
                end
            end else begin
                left <= left - 1'b1;
                if (left == 1) begin
                    tgt <= TGT_NONE;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/noc_msg_pkg.sv ====
`default_nettype none
`include "rs_tile_defs.svh"

package noc_msg_pkg;

    typedef enum logic [`FBITS_WIDTH-1:0] {
        PKT_IN     = 4'd1,
        PKT_OUT    = 4'd2,
        STATS_REQ  = 4'd3,
        STATS_RESP = 4'd4
    } msg_type_e;

    localparam int TAG_WIDTH = 16;

    // header layout, type on top then length then tag
    localparam int TYPE_MSB = `NOC_DATA_WIDTH - 1;
    localparam int TYPE_LSB = `NOC_DATA_WIDTH - `FBITS_WIDTH;
    localparam int LEN_MSB  = TYPE_LSB - 1;
    localparam int LEN_LSB  = TYPE_LSB - `MSG_LEN_WIDTH;
    localparam int TAG_MSB  = LEN_LSB - 1;
    localparam int TAG_LSB  = LEN_LSB - TAG_WIDTH;

    function automatic logic [`FBITS_WIDTH-1:0] hdr_type(input logic [`NOC_DATA_WIDTH-1:0] flit);
        return flit[TYPE_MSB:TYPE_LSB];
    endfunction

    function automatic logic [`MSG_LEN_WIDTH-1:0] hdr_len(input logic [`NOC_DATA_WIDTH-1:0] flit);
        return flit[LEN_MSB:LEN_LSB];
    endfunction

    function automatic logic [TAG_WIDTH-1:0] hdr_tag(input logic [`NOC_DATA_WIDTH-1:0] flit);
        return flit[TAG_MSB:TAG_LSB];
    endfunction

    function automatic logic [`NOC_DATA_WIDTH-1:0] make_hdr(
        input msg_type_e                 msg_type,
        input logic [`MSG_LEN_WIDTH-1:0] len,
        input logic [TAG_WIDTH-1:0]      tag
    );
        logic [`NOC_DATA_WIDTH-1:0] hdr;
        hdr = '0;
        hdr[TYPE_MSB:TYPE_LSB] = msg_type;
        hdr[LEN_MSB:LEN_LSB]   = len;
        hdr[TAG_MSB:TAG_LSB]   = tag;
        return hdr;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/noc_prio_merger.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rs_tile_defs.svh"

module noc_prio_merger
    import noc_msg_pkg::*;
(
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            src0_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   src0_data
    ,output logic                           src0_rdy

    ,input  wire                            src1_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   src1_data
    ,output logic                           src1_rdy

    ,output logic                           out_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   out_data
    ,input  wire                            out_rdy
);

    typedef enum logic [1:0] {
        MRG_IDLE,
        MRG_HDR,
        MRG_BODY
    } merge_state_e;

    merge_state_e               state;
    logic                       owner;
    logic                       sel;
    logic [`MSG_LEN_WIDTH-1:0]  left;
    logic                       out_hs;

    // stats side wins only when nothing is pending
    assign sel = (state == MRG_IDLE) ? src1_val : owner;

    assign out_val  = sel ? src1_val : src0_val;
    assign out_data = sel ? src1_data : src0_data;
    assign src0_rdy = out_rdy & ~sel;
    assign src1_rdy = out_rdy & sel;
    assign out_hs   = out_val & out_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MRG_IDLE;
            owner <= 1'b0;
            left  <= '0;
        end else if (state == MRG_BODY) begin
            if (out_hs) begin
                left <= left - 1'b1;
                if (left == 1) begin
                    state <= MRG_IDLE;
                end
            end
        end else if (out_hs) begin
            owner <= sel;
            left  <= hdr_len(out_data);
            state <= (hdr_len(out_data) == '0) ? MRG_IDLE : MRG_BODY;
        end else if (out_val) begin
            // header offered but stalled, keep the choice
            owner <= sel;
            state <= MRG_HDR;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rs_code_pkg.sv ====
`default_nettype none
`include "rs_tile_defs.svh"

package rs_code_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PKT_HDR,
        PKT_DATA,
        PKT_PARITY,
        STAT_HDR,
        STAT_DATA
    } enc_state_e;

    localparam int PARITY_SYMS  = `RS_PARITY_SYMS;
    localparam int PARITY_WIDTH = 8 * PARITY_SYMS;

    // g(x) = (x+1)(x+2)(x+4)(x+8), monic term left out
    // coefficients of x^3 down to x^0
    localparam logic [7:0] RS_GEN [PARITY_SYMS] = '{8'h0F, 8'h36, 8'h78, 8'h40};

    // multiply in GF(2^8), polynomial 0x11D
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] prod;
        logic [7:0] acc;
        prod = 8'h00;
        acc  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                prod = prod ^ acc;
            end
            acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1D : 8'h00);
        end
        return prod;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/rs_encode_tile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rs_tile_defs.svh"

module rs_encode_tile (
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            in_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   in_data
    ,output logic                           in_rdy

    ,output logic                           out_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   out_data
    ,input  wire                            out_rdy
);

    logic                           dec_fifo_val;
    logic   [`NOC_DATA_WIDTH-1:0]   dec_fifo_data;
    logic                           fifo_dec_rdy;

    logic                           dec_stat_val;
    logic   [`NOC_DATA_WIDTH-1:0]   dec_stat_data;
    logic                           stat_dec_rdy;

    logic                           fifo_wr_req;
    logic                           fifo_full;
    logic                           fifo_rd_req;
    logic                           fifo_empty;

    logic                           fifo_eng_val;
    logic   [`NOC_DATA_WIDTH-1:0]   fifo_eng_data;
    logic                           eng_fifo_rdy;

    logic                           eng_pkt_merger_val;
    logic   [`NOC_DATA_WIDTH-1:0]   eng_pkt_merger_data;
    logic                           merger_eng_pkt_rdy;

    logic                           eng_stat_merger_val;
    logic   [`NOC_DATA_WIDTH-1:0]   eng_stat_merger_data;
    logic                           merger_eng_stat_rdy;

    noc_fbits_decode decode (
         .clk       (clk            )
        ,.rst       (rst            )
        ,.in_val    (in_val         )
        ,.in_data   (in_data        )
        ,.in_rdy    (in_rdy         )
        ,.pkt_val   (dec_fifo_val   )
        ,.pkt_data  (dec_fifo_data  )
        ,.pkt_rdy   (fifo_dec_rdy   )
        ,.stat_val  (dec_stat_val   )
        ,.stat_data (dec_stat_data  )
        ,.stat_rdy  (stat_dec_rdy   )
    );

    // val/rdy glue around the packet buffer
    assign fifo_dec_rdy = ~fifo_full;
    assign fifo_wr_req  = dec_fifo_val & ~fifo_full;
    assign fifo_eng_val = ~fifo_empty;
    assign fifo_rd_req  = fifo_eng_val & eng_fifo_rdy;

    flit_fifo #(
         .WIDTH         (`NOC_DATA_WIDTH    )
        ,.LOG2_DEPTH    (`FIFO_LOG2_DEPTH   )
    ) pkt_fifo (
         .clk       (clk            )
        ,.rst       (rst            )
        ,.wr_req    (fifo_wr_req    )
        ,.wr_data   (dec_fifo_data  )
        ,.full      (fifo_full      )
        ,.rd_req    (fifo_rd_req    )
        ,.rd_data   (fifo_eng_data  )
        ,.empty     (fifo_empty     )
    );

    rs_parity_engine execute (
         .clk           (clk                    )
        ,.rst           (rst                    )
        ,.pkt_in_val    (fifo_eng_val           )
        ,.pkt_in_data   (fifo_eng_data          )
        ,.pkt_in_rdy    (eng_fifo_rdy           )
        ,.stat_in_val   (dec_stat_val           )
        ,.stat_in_data  (dec_stat_data          )
        ,.stat_in_rdy   (stat_dec_rdy           )
        ,.pkt_out_val   (eng_pkt_merger_val     )
        ,.pkt_out_data  (eng_pkt_merger_data    )
        ,.pkt_out_rdy   (merger_eng_pkt_rdy     )
        ,.stat_out_val  (eng_stat_merger_val    )
        ,.stat_out_data (eng_stat_merger_data   )
        ,.stat_out_rdy  (merger_eng_stat_rdy    )
    );

    noc_prio_merger result (
         .clk       (clk                    )
        ,.rst       (rst                    )
        ,.src0_val  (eng_pkt_merger_val     )
        ,.src0_data (eng_pkt_merger_data    )
        ,.src0_rdy  (merger_eng_pkt_rdy     )
        ,.src1_val  (eng_stat_merger_val    )
        ,.src1_data (eng_stat_merger_data   )
        ,.src1_rdy  (merger_eng_stat_rdy    )
        ,.out_val   (out_val                )
        ,.out_data  (out_data               )
        ,.out_rdy   (out_rdy                )
    );

endmodule

`default_nettype wire

// ==== hdl/rs_parity_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rs_tile_defs.svh"

module rs_parity_engine
    import noc_msg_pkg::*;
    import rs_code_pkg::*;
(
     input  wire                            clk
    ,input  wire                            rst

    ,input  wire                            pkt_in_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   pkt_in_data
    ,output logic                           pkt_in_rdy

    ,input  wire                            stat_in_val
    ,input  wire    [`NOC_DATA_WIDTH-1:0]   stat_in_data
    ,output logic                           stat_in_rdy

    ,output logic                           pkt_out_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   pkt_out_data
    ,input  wire                            pkt_out_rdy

    ,output logic                           stat_out_val
    ,output logic   [`NOC_DATA_WIDTH-1:0]   stat_out_data
    ,input  wire                            stat_out_rdy
);

    localparam int CNT_WIDTH  = `NOC_DATA_WIDTH / 2;
    localparam int FLIT_BYTES = `NOC_DATA_WIDTH / 8;

    enc_state_e                 state;
    logic [`MSG_LEN_WIDTH-1:0]  left;
    logic [`MSG_LEN_WIDTH-1:0]  pkt_len;
    logic [TAG_WIDTH-1:0]       stat_tag;
    logic [PARITY_WIDTH-1:0]    rem;
    logic [CNT_WIDTH-1:0]       pkt_cnt;
    logic [CNT_WIDTH-1:0]       byte_cnt;
    logic                       pkt_in_hs;
    logic                       stat_in_hs;

    // one LFSR step per byte, most significant byte first
    function automatic logic [PARITY_WIDTH-1:0] rs_flit_step(
        input logic [PARITY_WIDTH-1:0]      r_in,
        input logic [`NOC_DATA_WIDTH-1:0]   flit
    );
        logic [PARITY_WIDTH-1:0] r;
        logic [7:0]              fb;
        r = r_in;
        for (int b = FLIT_BYTES - 1; b >= 0; b--) begin
            fb = flit[8*b +: 8] ^ r[PARITY_WIDTH-1 -: 8];
            for (int i = 0; i < PARITY_SYMS - 1; i++) begin
                r[PARITY_WIDTH-1-8*i -: 8] = r[PARITY_WIDTH-9-8*i -: 8] ^ gf_mul(fb, RS_GEN[i]);
            end
            r[7:0] = gf_mul(fb, RS_GEN[PARITY_SYMS-1]);
        end
        return r;
    endfunction

    always_comb begin
        pkt_in_rdy    = 1'b0;
        pkt_out_val   = 1'b0;
        pkt_out_data  = pkt_in_data;
        stat_in_rdy   = 1'b0;
        stat_out_val  = 1'b0;
        stat_out_data = {pkt_cnt, byte_cnt};
        case (state)
            IDLE: stat_in_rdy = 1'b1;
            PKT_HDR: begin
                pkt_out_val  = pkt_in_val;
                pkt_in_rdy   = pkt_out_rdy;
                // parity flit adds one to the length
                pkt_out_data = make_hdr(PKT_OUT, hdr_len(pkt_in_data) + 1'b1,
                                        hdr_tag(pkt_in_data));
            end
            PKT_DATA: begin
                pkt_out_val = pkt_in_val;
                pkt_in_rdy  = pkt_out_rdy;
            end
            PKT_PARITY: begin
                pkt_out_val  = 1'b1;
                pkt_out_data = {{(`NOC_DATA_WIDTH-PARITY_WIDTH){1'b0}}, rem};
            end
            STAT_HDR: begin
                // drain request body before replying
                stat_in_rdy   = (left != '0);
                stat_out_val  = (left == '0);
                stat_out_data = make_hdr(STATS_RESP, 8'd1, stat_tag);
            end
            STAT_DATA: stat_out_val = 1'b1;
            default: ;
        endcase
    end

    assign pkt_in_hs  = pkt_in_val & pkt_in_rdy;
    assign stat_in_hs = stat_in_val & stat_in_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            left     <= '0;
            pkt_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (stat_in_val) begin
                        left  <= hdr_len(stat_in_data);
                        state <= STAT_HDR;
                    end else if (pkt_in_val) begin
                        state <= PKT_HDR;
                    end
                end
                PKT_HDR: begin
                    if (pkt_in_hs) begin
                        left  <= hdr_len(pkt_in_data);
                        state <= (hdr_len(pkt_in_data) == '0) ? PKT_PARITY : PKT_DATA;
                    end
                end
                PKT_DATA: begin
                    if (pkt_in_hs) begin
                        left <= left - 1'b1;
                        if (left == 1) begin
                            state <= PKT_PARITY;
                        end
                    end
                end
                PKT_PARITY: begin
                    if (pkt_out_rdy) begin
                        pkt_cnt  <= pkt_cnt + 1'b1;
                        byte_cnt <= byte_cnt + CNT_WIDTH'({pkt_len, 3'b000});
                        state    <= IDLE;
                    end
                end
                STAT_HDR: begin
                    if (stat_in_hs) begin
                        left <= left - 1'b1;
                    end
                    if (stat_out_val && stat_out_rdy) begin
                        state <= STAT_DATA;
                    end
                end
                STAT_DATA: begin
                    if (stat_out_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && stat_in_val) begin
            stat_tag <= hdr_tag(stat_in_data);
        end
        if (state == PKT_HDR && pkt_in_hs) begin
            pkt_len <= hdr_len(pkt_in_data);
            rem     <= '0;
        end else if (state == PKT_DATA && pkt_in_hs) begin
            rem <= rs_flit_step(rem, pkt_in_data);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rs_tile_defs.svh ====
`ifndef RS_TILE_DEFS_SVH
`define RS_TILE_DEFS_SVH

// flit width of the network
`define NOC_DATA_WIDTH 64

// header fields
`define FBITS_WIDTH 4
`define MSG_LEN_WIDTH 8

// parity symbols per packet, one byte each
`define RS_PARITY_SYMS 4

// packet buffer depth as log2
`define FIFO_LOG2_DEPTH 5

`endif

// ==== tb.f ====
+incdir+hdl
hdl/noc_msg_pkg.sv
hdl/rs_code_pkg.sv
hdl/noc_fbits_decode.sv
hdl/flit_fifo.sv
hdl/rs_parity_engine.sv
hdl/noc_prio_merger.sv
hdl/rs_encode_tile.sv
bench/tb_clock.sv
bench/rs_encode_tile_tb.sv
